//--- hdl/hygro_pkg.sv
/* hygro reader shared definitions
   bus drive, reading and digit types, FSM enums, ascii and protocol constants */
package hygro_pkg;

	localparam int VALUE_BITS = 14; // sensor resolution
	localparam int BCD_DIGITS = 5;
	localparam int READ_BYTES = 4;
	localparam int LINE_CHARS = 2 * BCD_DIGITS + 3; // digits, space, digits, cr, lf

	typedef logic [7:0] char_t;

	localparam char_t ASCII_ZERO = 8'h30;
	localparam char_t ASCII_SPACE = 8'h20;
	localparam char_t ASCII_CR = 8'h0d;
	localparam char_t ASCII_LF = 8'h0a;

	// open drain, so the master only ever pulls sda low
	typedef struct packed {
		logic scl;
		logic sda_low;
	} bus_drive_t;

	typedef struct packed {
		logic [VALUE_BITS-1:0] humidity;
		logic [VALUE_BITS-1:0] temperature;
	} reading_t;

	typedef logic [BCD_DIGITS-1:0][3:0] digits_t; // digit 0 is the units

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_READ,
		SEQ_CONVERT,
		SEQ_PRINT
	} seq_state_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_START,
		PH_ADDR,
		PH_ADDR_ACK,
		PH_DATA,
		PH_MASTER_ACK,
		PH_STOP
	} i2c_phase_t;

endpackage

//--- hdl/i2c_read_engine.sv
`timescale 1ns/100ps
/* i2c read engine
   start, address with read bit, four data bytes with master acks, then stop */
module i2c_read_engine #(
	parameter logic [6:0] sensor_addr = 7'h27,
	parameter int quarter_bit_clocks = 63
) (
	input logic clock,
	input logic uart_resetb,
	input logic read_start,
	input logic sda_in,
	output hygro_pkg::bus_drive_t bus,
	output logic read_done,
	output logic nack,
	output hygro_pkg::reading_t reading
);
	import hygro_pkg::*;

	localparam int DIV_W = $clog2(quarter_bit_clocks + 1);
	localparam int BYTE_W = $clog2(READ_BYTES);

	i2c_phase_t phase;
	logic [DIV_W-1:0] div_count;
	logic [1:0] quarter;
	logic [2:0] bit_idx;
	logic [BYTE_W-1:0] byte_idx;
	logic [READ_BYTES*8-1:0] rx_shift;
	logic [7:0] addr_byte;
	logic quarter_tick;
	logic scl_high;
	logic sample_now;
	logic last_byte;
	bus_drive_t bus_next;

	assign addr_byte = {sensor_addr, 1'b1}; // r/w bit set for a read
	assign quarter_tick = (phase != PH_IDLE) && (div_count == DIV_W'(quarter_bit_clocks - 1));
	// each bit is low, high, high, low
	assign scl_high = (quarter == 2'd1) || (quarter == 2'd2);
	assign sample_now = quarter_tick && (quarter == 2'd2); // end of the high half
	assign last_byte = (byte_idx == BYTE_W'(READ_BYTES - 1));

	always_comb begin
		bus_next.scl = scl_high;
		bus_next.sda_low = 1'b0;
		case (phase)
			PH_IDLE: bus_next.scl = 1'b1;
			PH_START: begin
				bus_next.scl = (quarter != 2'd3);
				bus_next.sda_low = (quarter >= 2'd2); // sda falls while scl high
			end
			PH_ADDR: bus_next.sda_low = ~addr_byte[bit_idx];
			PH_ADDR_ACK: bus_next.sda_low = 1'b0; // sensor drives the ack
			PH_DATA: bus_next.sda_low = 1'b0;
			PH_MASTER_ACK: bus_next.sda_low = ~last_byte; // nack the final byte
			PH_STOP: begin
				bus_next.scl = (quarter != 2'd0);
				bus_next.sda_low = (quarter <= 2'd1); // released after scl is high
			end
			default: bus_next.scl = 1'b1;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			phase <= PH_IDLE;
			div_count <= '0;
			quarter <= 2'd0;
			bit_idx <= 3'd0;
			byte_idx <= '0;
			nack <= 1'b0;
			read_done <= 1'b0;
			bus <= '{scl: 1'b1, sda_low: 1'b0};
		end else begin
			read_done <= 1'b0;
			bus <= bus_next;
			if (phase == PH_IDLE) begin
				div_count <= '0;
				quarter <= 2'd0;
				if (read_start) begin
					phase <= PH_START;
					nack <= 1'b0;
				end
			end else if (quarter_tick) begin
				div_count <= '0;
				quarter <= quarter + 2'd1;
				if (sample_now && phase == PH_ADDR_ACK)
					nack <= sda_in; // high means nobody answered
				if (quarter == 2'd3) begin
					case (phase)
						PH_START: begin
							phase <= PH_ADDR;
							bit_idx <= 3'd7;
						end
						PH_ADDR: begin
							if (bit_idx == 3'd0)
								phase <= PH_ADDR_ACK;
							else
								bit_idx <= bit_idx - 3'd1;
						end
						PH_ADDR_ACK: begin
							phase <= nack ? PH_STOP : PH_DATA;
							bit_idx <= 3'd7;
							byte_idx <= '0;
						end
						PH_DATA: begin
							if (bit_idx == 3'd0)
								phase <= PH_MASTER_ACK;
							else
								bit_idx <= bit_idx - 3'd1;
						end
						PH_MASTER_ACK: begin
							if (last_byte) begin
								phase <= PH_STOP;
							end else begin
								phase <= PH_DATA;
								byte_idx <= byte_idx + 1'b1;
								bit_idx <= 3'd7;
							end
						end
						PH_STOP: begin
							phase <= PH_IDLE;
							read_done <= 1'b1;
						end
						default: phase <= PH_IDLE;
					endcase
				end
			end else begin
				div_count <= div_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (sample_now && phase == PH_DATA)
			rx_shift <= {rx_shift[READ_BYTES*8-2:0], sda_in}; // msb first
		if (quarter_tick && quarter == 2'd3 && phase == PH_STOP) begin
			// low 6 bits of byte 0 and byte 1, then byte 2 and top 6 bits of byte 3
			reading <= '{humidity: rx_shift[29:16], temperature: rx_shift[15:2]};
		end
	end

endmodule

//--- hdl/bin_to_bcd.sv
`timescale 1ns/100ps
/* binary to bcd converter
   double dabble, one input bit per clock */
module bin_to_bcd (
	input logic clock,
	input logic uart_resetb,
	input logic conv_start,
	input logic [hygro_pkg::VALUE_BITS-1:0] value,
	output logic conv_done,
	output hygro_pkg::digits_t digits
);
	import hygro_pkg::*;

	localparam int COUNT_W = $clog2(VALUE_BITS + 1);

	logic [COUNT_W-1:0] bits_left;
	logic [VALUE_BITS-1:0] bin_shift;
	digits_t adjusted;

	// add three to every digit that would overflow on the next shift
	always_comb begin
		adjusted = digits;
		for (int i = 0; i < BCD_DIGITS; i++) begin
			if (digits[i] >= 4'd5)
				adjusted[i] = digits[i] + 4'd3;
		end
	end

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			bits_left <= '0;
			conv_done <= 1'b0;
		end else begin
			conv_done <= 1'b0;
			if (conv_start) begin
				bits_left <= COUNT_W'(VALUE_BITS);
			end else if (bits_left != '0) begin
				bits_left <= bits_left - 1'b1;
				conv_done <= (bits_left == COUNT_W'(1)); // last shift
			end
		end
	end

	always_ff @(posedge clock) begin
		if (conv_start) begin
			digits <= '0;
			bin_shift <= value;
		end else if (bits_left != '0) begin
			{digits, bin_shift} <= {adjusted, bin_shift} << 1;
		end
	end

endmodule

//--- hdl/report_formatter.sv
`timescale 1ns/100ps
/* report line formatter
   humidity digits, space, temperature digits, cr, lf as an ascii stream */
module report_formatter (
	input logic clock,
	input logic uart_resetb,
	input logic print_start,
	input hygro_pkg::digits_t humidity_digits,
	input hygro_pkg::digits_t temperature_digits,
	input logic char_ready,
	output logic char_valid,
	output hygro_pkg::char_t char,
	output logic print_done
);
	import hygro_pkg::*;

	localparam int IDX_W = $clog2(LINE_CHARS);
	localparam int SPACE_POS = BCD_DIGITS;
	localparam int CR_POS = 2 * BCD_DIGITS + 1;
	localparam int LF_POS = LINE_CHARS - 1;

	logic [IDX_W-1:0] idx;
	logic accepted;

	function automatic char_t to_ascii(logic [3:0] digit);
		return ASCII_ZERO + char_t'(digit);
	endfunction

	assign accepted = char_valid && char_ready;

	// most significant digit goes out first
	always_comb begin
		if (idx < IDX_W'(SPACE_POS))
			char = to_ascii(humidity_digits[SPACE_POS - 1 - idx]);
		else if (idx == IDX_W'(SPACE_POS))
			char = ASCII_SPACE;
		else if (idx < IDX_W'(CR_POS))
			char = to_ascii(temperature_digits[CR_POS - 1 - idx]);
		else if (idx == IDX_W'(CR_POS))
			char = ASCII_CR;
		else
			char = ASCII_LF;
	end

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			idx <= '0;
			char_valid <= 1'b0;
			print_done <= 1'b0;
		end else begin
			print_done <= 1'b0;
			if (print_start) begin
				idx <= '0;
				char_valid <= 1'b1;
			end else if (accepted) begin
				if (idx == IDX_W'(LF_POS)) begin
					char_valid <= 1'b0; // line complete
					print_done <= 1'b1;
				end else begin
					idx <= idx + 1'b1; // next char offered right away
				end
			end
		end
	end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/100ps
/* uart transmitter, 8N1
   lsb first, each bit held for baud_clocks cycles */
module uart_tx #(
	parameter int baud_clocks = 417
) (
	input logic clock,
	input logic uart_resetb,
	input logic char_valid,
	input hygro_pkg::char_t char,
	output logic char_ready,
	output logic tx
);
	import hygro_pkg::*;

	localparam int BAUD_W = $clog2(baud_clocks + 1);

	logic busy;
	logic [BAUD_W-1:0] baud_count;
	logic [3:0] bits_left;
	logic [$bits(char_t):0] shift_reg; // data bits then the stop bit
	logic baud_tick;

	assign char_ready = ~busy;
	assign baud_tick = busy && (baud_count == BAUD_W'(baud_clocks - 1));

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			busy <= 1'b0;
			baud_count <= '0;
			bits_left <= 4'd0;
			tx <= 1'b1; // line idles high
		end else if (!busy) begin
			baud_count <= '0;
			if (char_valid) begin
				busy <= 1'b1;
				bits_left <= 4'($bits(char_t) + 1);
				tx <= 1'b0; // start bit
			end
		end else if (baud_tick) begin
			baud_count <= '0;
			if (bits_left == 4'd0) begin
				busy <= 1'b0; // stop bit done
			end else begin
				tx <= shift_reg[0];
				bits_left <= bits_left - 4'd1;
			end
		end else begin
			baud_count <= baud_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!busy && char_valid)
			shift_reg <= {1'b1, char};
		else if (baud_tick)
			shift_reg <= shift_reg >> 1;
	end

endmodule

//--- hdl/hygro_sequencer.sv
`timescale 1ns/100ps
/* measurement sequencer
   accepts a request, then orders the i2c read, bcd conversion and printing */
module hygro_sequencer (
	input logic clock,
	input logic uart_resetb,
	input logic measure_valid,
	input logic read_done,
	input logic nack,
	input logic conv_done,
	input logic print_done,
	output logic measure_ready,
	output logic read_start,
	output logic conv_start,
	output logic print_start,
	output logic error
);
	import hygro_pkg::*;

	seq_state_t state;

	assign measure_ready = (state == SEQ_IDLE);

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			state <= SEQ_IDLE;
			read_start <= 1'b0;
			conv_start <= 1'b0;
			print_start <= 1'b0;
			error <= 1'b0;
		end else begin
			read_start <= 1'b0;
			conv_start <= 1'b0;
			print_start <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (measure_valid) begin // ready is implied in idle
						state <= SEQ_READ;
						read_start <= 1'b1;
						error <= 1'b0;
					end
				end
				SEQ_READ: begin
					if (read_done) begin
						if (nack) begin
							state <= SEQ_IDLE; // sensor absent, nothing to print
							error <= 1'b1;
						end else begin
							state <= SEQ_CONVERT;
							conv_start <= 1'b1;
						end
					end
				end
				SEQ_CONVERT: begin
					if (conv_done) begin
						state <= SEQ_PRINT;
						print_start <= 1'b1;
					end
				end
				SEQ_PRINT: begin
					if (print_done)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/hygro_top.sv
`timescale 1ns/100ps
/* humidity and temperature reader, top level
   i2c sensor read on request, one ascii line out on the uart */
module hygro_top #(
	parameter logic [6:0] sensor_addr = 7'h27,
	parameter int quarter_bit_clocks = 63,
	parameter int baud_clocks = 417
) (
	input logic clock,
	input logic uart_resetb,
	input logic measure_valid,
	input logic sda_in,
	output logic measure_ready,
	output hygro_pkg::bus_drive_t bus,
	output logic tx,
	output logic error
);
	import hygro_pkg::*;

	logic read_start;
	logic read_done;
	logic nack;
	logic conv_start;
	logic conv_done;
	logic print_start;
	logic print_done;
	logic char_valid;
	logic char_ready;
	reading_t reading;
	digits_t humidity_digits;
	digits_t temperature_digits;
	char_t tx_char;

	hygro_sequencer u_seq (
		.clock, .uart_resetb, .measure_valid, .read_done, .nack, .conv_done, .print_done,
		.measure_ready, .read_start, .conv_start, .print_start, .error
	);

	i2c_read_engine #(.sensor_addr(sensor_addr), .quarter_bit_clocks(quarter_bit_clocks)) u_engine (
		.clock, .uart_resetb, .read_start, .sda_in, .bus, .read_done, .nack, .reading
	);

	// both converters take the same time, humidity alone reports done
	bin_to_bcd u_hum_bcd (
		.clock, .uart_resetb, .conv_start, .value(reading.humidity),
		.conv_done, .digits(humidity_digits)
	);

	bin_to_bcd u_temp_bcd (
		.clock, .uart_resetb, .conv_start, .value(reading.temperature),
		.conv_done(), .digits(temperature_digits)
	);

	report_formatter u_fmt (
		.clock, .uart_resetb, .print_start, .humidity_digits, .temperature_digits,
		.char_ready, .char_valid, .char(tx_char), .print_done
	);

	uart_tx #(.baud_clocks(baud_clocks)) u_uart (
		.clock, .uart_resetb, .char_valid, .char(tx_char), .char_ready, .tx
	);

endmodule

//--- verif/hygro_checker.sv
`timescale 1ns/100ps
/* hygro reader protocol checker
   i2c data timing, request handshake and uart idle level */
module hygro_checker (
	input logic clock,
	input logic uart_resetb,
	input logic measure_valid,
	input logic measure_ready,
	input hygro_pkg::bus_drive_t bus,
	input logic tx,
	input hygro_pkg::i2c_phase_t phase,
	input logic tx_idle
);
	import hygro_pkg::*;

	// bus is registered, so it reflects the phase of the previous clock
	sda_stable_while_scl_high: assert property (
		@(posedge clock) disable iff (!uart_resetb)
		($changed(bus.sda_low) && bus.scl && $past(bus.scl))
			|-> ($past(phase) inside {PH_START, PH_STOP})
	) else $error("sda moved while scl was high outside start or stop");

	request_held_until_accepted: assert property (
		@(posedge clock) disable iff (!uart_resetb)
		(measure_valid && !measure_ready) |=> measure_valid
	) else $error("request withdrawn before it was accepted");

	ready_drops_after_accept: assert property (
		@(posedge clock) disable iff (!uart_resetb)
		(measure_valid && measure_ready) |=> !measure_ready
	) else $error("ready still high after an accepted request");

	tx_high_when_idle: assert property (
		@(posedge clock) disable iff (!uart_resetb)
		tx_idle |-> tx
	) else $error("uart line low while the transmitter is idle");

endmodule

bind hygro_top hygro_checker u_checker (
	.clock,
	.uart_resetb,
	.measure_valid,
	.measure_ready,
	.bus,
	.tx,
	.phase(u_engine.phase),
	.tx_idle(char_ready)
);

//--- verif/hygro_tb.sv
`timescale 1ns/100ps
/* hygro reader testbench
   i2c sensor model, uart receiver, request stimulus and line checks */
module hygro_tb;
	import hygro_pkg::*;

	localparam logic [6:0] SENSOR_ADDR = 7'h27;
	localparam int QUARTER = 2;
	localparam int BAUD = 8;
	localparam int WATCHDOG_CYCLES = 5 * 5000 + 2000; // five measurements plus margin

	logic clock = 1'b0;
	logic uart_resetb;
	logic measure_valid;
	logic sda_in;
	logic measure_ready;
	bus_drive_t bus;
	logic tx;
	logic error;

	logic slave_low; // sensor pulling sda low
	logic sensor_acks; // sensor answers its address
	logic sda_line;
	int seed = 32'h2f9a;
	string cur_test = "reset";
	logic [7:0] byte_log[$]; // bytes sent by the sensor in order
	logic [7:0] rx_q[$];

	hygro_top #(
		.sensor_addr(SENSOR_ADDR),
		.quarter_bit_clocks(QUARTER),
		.baud_clocks(BAUD)
	) uut (
		.clock, .uart_resetb, .measure_valid, .sda_in,
		.measure_ready, .bus, .tx, .error
	);

	always #20 clock = ~clock;

	assign sda_line = ~(bus.sda_low | slave_low); // open drain with pull-up
	assign sda_in = sda_line;

	task automatic fail_value(string what, int expected, int actual);
		$display("ERR %s expected %0d actual %0d", what, expected, actual);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// i2c sensor model on sampled bus values
	logic prev_scl;
	logic prev_sda;
	logic active;
	logic in_addr;
	int bit_cnt;
	int byte_cnt;
	logic [7:0] shift;
	logic [7:0] tx_bytes[4];

	always @(posedge clock) begin
		if (!uart_resetb) begin
			active = 1'b0;
			prev_scl = 1'b1;
			prev_sda = 1'b1;
			slave_low <= 1'b0;
		end else begin
			if (bus.scl && prev_scl && prev_sda && !sda_line) begin // start
				active = 1'b1;
				in_addr = 1'b1;
				bit_cnt = 0;
				byte_cnt = 0;
				for (int i = 0; i < READ_BYTES; i++) begin
					tx_bytes[i] = 8'($random(seed));
					byte_log.push_back(tx_bytes[i]);
				end
			end else if (bus.scl && prev_scl && !prev_sda && sda_line) begin // stop
				active = 1'b0;
				slave_low <= 1'b0;
			end else if (active && bus.scl && !prev_scl) begin
				if (bit_cnt < 8) begin
					shift = {shift[6:0], sda_line};
					bit_cnt++;
				end else if (in_addr) begin
					assert (shift == {SENSOR_ADDR, 1'b1})
						else fail_value({cur_test, " address byte"}, {SENSOR_ADDR, 1'b1}, shift);
					in_addr = 1'b0;
					bit_cnt = 0;
					if (!sensor_acks)
						active = 1'b0; // stay off the bus until the next start
				end else begin
					// master acks bytes 0 to 2 and nacks the last
					assert (sda_line == (byte_cnt == READ_BYTES - 1))
						else fail_value({cur_test, " master ack bit"},
							byte_cnt == READ_BYTES - 1, sda_line);
					byte_cnt++;
					bit_cnt = 0;
				end
			end else if (active && !bus.scl && prev_scl) begin
				if (in_addr)
					slave_low <= (bit_cnt == 8) && sensor_acks;
				else if (bit_cnt < 8 && byte_cnt < READ_BYTES)
					slave_low <= ~tx_bytes[byte_cnt][7 - bit_cnt];
				else
					slave_low <= 1'b0;
			end
			prev_scl = bus.scl;
			prev_sda = sda_line;
		end
	end

	// uart receiver sampling mid bit
	initial begin
		logic [7:0] ch;
		forever begin
			@(posedge clock);
			if (uart_resetb && !tx) begin
				repeat (BAUD / 2) @(posedge clock);
				for (int i = 0; i < 8; i++) begin
					repeat (BAUD) @(posedge clock);
					ch[i] = tx;
				end
				repeat (BAUD) @(posedge clock);
				assert (tx) else fail_value({cur_test, " stop bit"}, 1, tx);
				rx_q.push_back(ch);
			end
		end
	end

	function automatic string expected_line(logic [7:0] b0, logic [7:0] b1,
			logic [7:0] b2, logic [7:0] b3);
		logic [13:0] hum;
		logic [13:0] temp;
		hum = {b0[5:0], b1};
		temp = {b2, b3[7:2]};
		return $sformatf("%05d %05d\r\n", hum, temp);
	endfunction

	// returns the cycles spent waiting for acceptance
	task automatic send_request(output int waited);
		waited = 0;
		measure_valid <= 1'b1;
		do begin
			@(posedge clock);
			waited++;
		end while (!measure_ready);
		measure_valid <= 1'b0;
	endtask

	task automatic wait_ready();
		do @(posedge clock); while (!measure_ready);
	endtask

	task automatic check_line();
		string exp;
		logic [7:0] b[4];
		while (rx_q.size() < LINE_CHARS)
			@(posedge clock);
		for (int i = 0; i < 4; i++)
			b[i] = byte_log.pop_front();
		exp = expected_line(b[0], b[1], b[2], b[3]);
		for (int i = 0; i < LINE_CHARS; i++) begin
			logic [7:0] got;
			got = rx_q.pop_front();
			assert (got == exp[i])
				else fail_value($sformatf("%s char %0d", cur_test, i), exp[i], got);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired, the measurements did not complete in time");
		$display("TB FAILED");
		$fatal(1);
	end

	initial begin
		int waited;
		uart_resetb = 1'b0;
		measure_valid = 1'b0;
		sensor_acks = 1'b1;
		repeat (3) @(posedge clock);
		uart_resetb <= 1'b1;
		@(posedge clock);
		assert (measure_ready) else fail_value("reset ready", 1, measure_ready);
		assert (!error) else fail_value("reset error", 0, error);
		assert (bus.scl) else fail_value("reset scl", 1, bus.scl);
		assert (!bus.sda_low) else fail_value("reset sda_low", 0, bus.sda_low);
		assert (tx) else fail_value("reset tx", 1, tx);

		cur_test = "single";
		send_request(waited);
		wait_ready();
		check_line();
		assert (!error) else fail_value("single error", 0, error);

		cur_test = "nack";
		sensor_acks = 1'b0;
		send_request(waited);
		wait_ready();
		assert (error) else fail_value("nack error", 1, error);
		repeat (12 * BAUD) @(posedge clock);
		assert (rx_q.size() == 0) else fail_value("nack uart chars", 0, rx_q.size());
		void'(byte_log.pop_front()); // bytes never read by the master
		void'(byte_log.pop_front());
		void'(byte_log.pop_front());
		void'(byte_log.pop_front());

		cur_test = "back_to_back";
		sensor_acks = 1'b1;
		send_request(waited);
		@(posedge clock);
		assert (!error) else fail_value("error after accept", 0, error);
		send_request(waited); // held while the first one runs
		assert (waited > 1) else fail_value("held request wait", 2, waited);
		check_line();
		wait_ready();
		check_line();
		repeat (12 * BAUD) @(posedge clock); // long enough for a stray char to arrive
		assert (rx_q.size() == 0) else fail_value("extra uart chars", 0, rx_q.size());

		$display("TB PASSED");
		$finish;
	end

endmodule

//--- sim.f
hdl/hygro_pkg.sv
hdl/i2c_read_engine.sv
hdl/bin_to_bcd.sv
hdl/report_formatter.sv
hdl/uart_tx.sv
hdl/hygro_sequencer.sv
hdl/hygro_top.sv
verif/hygro_checker.sv
verif/hygro_tb.sv

//--- Makefile
TOP = hygro_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --assert --timing --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
